/* hdl/cpu_pkg.sv */
// cpu package: shared widths, ALU and forwarding encodings, pipeline constants
package cpu_pkg;

    // data and register index widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int REG_COUNT = 32;

    // ALU operation codes
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        NOR  = 4'd5,
        SLT  = 4'd6,
        SLTU = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9
    } alu_op_t;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    // issue queue depth, also the producer's starting credits
    localparam int ISSUE_CREDITS = 4;
    localparam int QPTR_W = $clog2(ISSUE_CREDITS);

    // data memory, word addressed by result bits 7:2
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;

endpackage

/* hdl/alu.sv */
// integer ALU: arithmetic, logic, compares and shifts with a zero flag
module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::word_t   port_a,
    input  cpu_pkg::word_t   port_b,
    output cpu_pkg::word_t   result,
    output logic             zero
);

    always_comb begin
        case (alu_op)
            cpu_pkg::ADD:  result = port_a + port_b;
            cpu_pkg::SUB:  result = port_a - port_b;
            cpu_pkg::AND:  result = port_a & port_b;
            cpu_pkg::OR:   result = port_a | port_b;
            cpu_pkg::XOR:  result = port_a ^ port_b;
            cpu_pkg::NOR:  result = ~(port_a | port_b);
            // signed and unsigned set-less-than
            cpu_pkg::SLT:  result = {31'd0, $signed(port_a) < $signed(port_b)};
            cpu_pkg::SLTU: result = {31'd0, port_a < port_b};
            // shift amount from b, shifted value is a
            cpu_pkg::SLL:  result = port_a << port_b[4:0];
            cpu_pkg::SRL:  result = port_a >> port_b[4:0];
            default:       result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hdl/forwarding_unit.sv */
// forwarding unit: picks register, memory-stage or writeback data per operand
module forwarding_unit (
    input  cpu_pkg::reg_addr_t ex_rs,
    input  cpu_pkg::reg_addr_t ex_rt,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  logic               mem_regwen,
    input  logic               wb_regwen,
    input  logic               mem_load,
    output cpu_pkg::fwd_sel_t  sel_a,
    output cpu_pkg::fwd_sel_t  sel_b
);

    // newest producer wins, so memory stage is checked first
    function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_addr_t src);
        cpu_pkg::fwd_sel_t sel;
        sel = cpu_pkg::FWD_NONE;
        if (src != '0) begin
            // a load in memory has no result yet, the load-use hold covers it
            if (mem_regwen && !mem_load && mem_rd == src) begin
                sel = cpu_pkg::FWD_MEM;
            end else if (wb_regwen && wb_rd == src) begin
                sel = cpu_pkg::FWD_WB;
            end
        end
        return sel;
    endfunction

    assign sel_a = pick(ex_rs);
    assign sel_b = pick(ex_rt);

endmodule

/* hdl/register_file.sv */
// register file: 32 words, two read ports with write-through, r0 reads zero
module register_file (
    input  logic               CLK,
    input  logic               nRST,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    input  logic               wen,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data
);

    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle writeback shows up on the read port, never for r0
    assign rs_data = (wen && wr_addr != '0 && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wen && wr_addr != '0 && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    // r0 stays zero across writes on both ports
    assert property (@(posedge CLK) disable iff (!nRST)
        (rs_addr == '0 |-> rs_data == '0) and (rt_addr == '0 |-> rt_data == '0));

endmodule

/* hdl/operand_stage.sv */
// operand stage: credit queue, load-use hold, operand read, decode-to-execute latch
module operand_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               op_valid,
    input  cpu_pkg::alu_op_t   op_alu,
    input  cpu_pkg::reg_addr_t op_rs,
    input  cpu_pkg::reg_addr_t op_rt,
    input  cpu_pkg::reg_addr_t op_rd,
    input  cpu_pkg::word_t     op_imm,
    input  logic               op_alusrc,
    input  logic               op_regwen,
    input  logic               op_load,
    input  logic               op_store,
    input  logic               freeze,
    input  logic               ex_load,
    input  cpu_pkg::reg_addr_t ex_rd,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    output logic               credit_return,
    output logic               id_valid,
    output cpu_pkg::alu_op_t   id_alu,
    output cpu_pkg::reg_addr_t id_rs,
    output cpu_pkg::reg_addr_t id_rt,
    output cpu_pkg::reg_addr_t id_rd,
    output cpu_pkg::word_t     id_a,
    output cpu_pkg::word_t     id_b,
    output cpu_pkg::word_t     id_imm,
    output logic               id_alusrc,
    output logic               id_regwen,
    output logic               id_load,
    output logic               id_store
);

    // queue storage, flags are {alusrc, regwen, load, store}
    cpu_pkg::alu_op_t   q_alu   [cpu_pkg::ISSUE_CREDITS];
    cpu_pkg::reg_addr_t q_rs    [cpu_pkg::ISSUE_CREDITS];
    cpu_pkg::reg_addr_t q_rt    [cpu_pkg::ISSUE_CREDITS];
    cpu_pkg::reg_addr_t q_rd    [cpu_pkg::ISSUE_CREDITS];
    cpu_pkg::word_t     q_imm   [cpu_pkg::ISSUE_CREDITS];
    logic [3:0]         q_flags [cpu_pkg::ISSUE_CREDITS];

    logic [cpu_pkg::QPTR_W-1:0] wr_ptr;
    logic [cpu_pkg::QPTR_W-1:0] rd_ptr;
    logic [cpu_pkg::QPTR_W:0]   count;
    logic                       hazard;
    logic                       move;

    // register file is read for the queue head
    assign rs_addr = q_rs[rd_ptr];
    assign rt_addr = q_rt[rd_ptr];

    // load in execute feeding the head costs one bubble
    assign hazard = ex_load && ex_rd != '0 && (ex_rd == rs_addr || ex_rd == rt_addr);
    assign move = (count != '0) && !freeze && !hazard;
    assign credit_return = move;

    always_ff @(posedge CLK) begin
        if (op_valid) begin
            q_alu[wr_ptr]   <= op_alu;
            q_rs[wr_ptr]    <= op_rs;
            q_rt[wr_ptr]    <= op_rt;
            q_rd[wr_ptr]    <= op_rd;
            q_imm[wr_ptr]   <= op_imm;
            q_flags[wr_ptr] <= {op_alusrc, op_regwen, op_load, op_store};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (op_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (move) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({op_valid, move})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // execute latch control, a stall or empty queue loads a bubble
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            id_valid  <= 1'b0;
            id_regwen <= 1'b0;
            id_load   <= 1'b0;
            id_store  <= 1'b0;
            id_rd     <= '0;
        end else if (!freeze) begin
            id_valid  <= move;
            id_regwen <= move && q_flags[rd_ptr][2];
            id_load   <= move && q_flags[rd_ptr][1];
            id_store  <= move && q_flags[rd_ptr][0];
            id_rd     <= q_rd[rd_ptr];
        end
    end

    // execute latch payload
    always_ff @(posedge CLK) begin
        if (move) begin
            id_alu    <= q_alu[rd_ptr];
            id_rs     <= q_rs[rd_ptr];
            id_rt     <= q_rt[rd_ptr];
            id_a      <= rs_data;
            id_b      <= rt_data;
            id_imm    <= q_imm[rd_ptr];
            id_alusrc <= q_flags[rd_ptr][3];
        end
    end

    // producer only issues while holding a credit
    assert property (@(posedge CLK) disable iff (!nRST)
        op_valid |-> count < cpu_pkg::ISSUE_CREDITS);

endmodule

/* hdl/execute_stage.sv */
// execute stage: forwarded operand muxing, ALU and the execute-to-memory latch
module execute_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               freeze,
    input  logic               id_valid,
    input  cpu_pkg::alu_op_t   id_alu,
    input  cpu_pkg::reg_addr_t id_rs,
    input  cpu_pkg::reg_addr_t id_rt,
    input  cpu_pkg::reg_addr_t id_rd,
    input  cpu_pkg::word_t     id_a,
    input  cpu_pkg::word_t     id_b,
    input  cpu_pkg::word_t     id_imm,
    input  logic               id_alusrc,
    input  logic               id_regwen,
    input  logic               id_load,
    input  logic               id_store,
    input  cpu_pkg::word_t     mem_fwd_data,
    input  cpu_pkg::word_t     wb_fwd_data,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  logic               mem_regwen,
    input  logic               wb_regwen,
    input  logic               mem_load,
    output logic               mem_valid,
    output cpu_pkg::reg_addr_t mem_rd_out,
    output logic               mem_regwen_out,
    output logic               mem_load_out,
    output logic               mem_store_out,
    output cpu_pkg::word_t     mem_result,
    output cpu_pkg::word_t     mem_store_data
);

    cpu_pkg::fwd_sel_t sel_a;
    cpu_pkg::fwd_sel_t sel_b;
    cpu_pkg::word_t    fwd_a;
    cpu_pkg::word_t    fwd_b;
    cpu_pkg::word_t    alu_b;
    cpu_pkg::word_t    alu_result;

    function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                               input cpu_pkg::word_t reg_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_fwd_data;
            cpu_pkg::FWD_WB:  return wb_fwd_data;
            default:          return reg_val;
        endcase
    endfunction

    forwarding_unit i_fwd (
        .ex_rs      (id_rs),
        .ex_rt      (id_rt),
        .mem_rd     (mem_rd),
        .wb_rd      (wb_rd),
        .mem_regwen (mem_regwen),
        .wb_regwen  (wb_regwen),
        .mem_load   (mem_load),
        .sel_a      (sel_a),
        .sel_b      (sel_b)
    );

    assign fwd_a = fwd_mux(sel_a, id_a);
    assign fwd_b = fwd_mux(sel_b, id_b);
    // immediate takes priority over a forwarded rt
    assign alu_b = id_alusrc ? id_imm : fwd_b;

    alu i_alu (
        .alu_op (id_alu),
        .port_a (fwd_a),
        .port_b (alu_b),
        .result (alu_result),
        .zero   ()
    );

    // memory latch control, held while frozen
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_valid      <= 1'b0;
            mem_rd_out     <= '0;
            mem_regwen_out <= 1'b0;
            mem_load_out   <= 1'b0;
            mem_store_out  <= 1'b0;
        end else if (!freeze) begin
            mem_valid      <= id_valid;
            mem_rd_out     <= id_rd;
            mem_regwen_out <= id_regwen;
            mem_load_out   <= id_load;
            mem_store_out  <= id_store;
        end
    end

    always_ff @(posedge CLK) begin
        if (!freeze) begin
            mem_result     <= alu_result;
            mem_store_data <= fwd_b;
        end
    end

endmodule

/* hdl/memory_stage.sv */
// memory stage: data memory with wait stalls and the memory-to-writeback latch
module memory_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               mem_wait,
    input  logic               mem_valid,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               mem_regwen,
    input  logic               mem_load,
    input  logic               mem_store,
    input  cpu_pkg::word_t     mem_result,
    input  cpu_pkg::word_t     mem_store_data,
    output logic               freeze,
    output logic               wb_valid,
    output cpu_pkg::reg_addr_t wb_rd,
    output logic               wb_regwen,
    output cpu_pkg::word_t     wb_data
);

    cpu_pkg::word_t                  dmem [cpu_pkg::DMEM_WORDS];
    logic [cpu_pkg::DMEM_ADDR_W-1:0] addr;

    assign addr = mem_result[cpu_pkg::DMEM_ADDR_W+1:2];

    // only a memory operation waits on the data side
    assign freeze = mem_wait && (mem_load || mem_store);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_store && !mem_wait) begin
            dmem[addr] <= mem_store_data;
        end
    end

    // writeback latch control
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_valid  <= 1'b0;
            wb_rd     <= '0;
            wb_regwen <= 1'b0;
        end else if (freeze) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid  <= mem_valid;
            wb_rd     <= mem_rd;
            wb_regwen <= mem_regwen;
        end
    end

    // bubble keeps the last write so writeback forwarding survives the stall,
    // rewriting the same register is harmless
    always_ff @(posedge CLK) begin
        if (!freeze) begin
            wb_data <= mem_load  ? dmem[addr] :
                       mem_store ? mem_store_data : mem_result;
        end
    end

    // execute never latches a load that is also a store
    assert property (@(posedge CLK) disable iff (!nRST)
        mem_valid |-> !(mem_load && mem_store));

endmodule

/* hdl/datapath_top.sv */
// datapath top: queue, register file, execute and memory stages with retire out
module datapath_top (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               op_valid,
    input  cpu_pkg::alu_op_t   op_alu,
    input  cpu_pkg::reg_addr_t op_rs,
    input  cpu_pkg::reg_addr_t op_rt,
    input  cpu_pkg::reg_addr_t op_rd,
    input  cpu_pkg::word_t     op_imm,
    input  logic               op_alusrc,
    input  logic               op_regwen,
    input  logic               op_load,
    input  logic               op_store,
    input  logic               mem_wait,
    output logic               credit_return,
    output logic               retire_valid,
    output cpu_pkg::reg_addr_t retire_rd,
    output logic               retire_regwen,
    output cpu_pkg::word_t     retire_data
);

    logic               freeze;
    cpu_pkg::reg_addr_t rs_addr, rt_addr;
    cpu_pkg::word_t     rs_data, rt_data;

    logic               id_valid, id_alusrc, id_regwen, id_load, id_store;
    cpu_pkg::alu_op_t   id_alu;
    cpu_pkg::reg_addr_t id_rs, id_rt, id_rd;
    cpu_pkg::word_t     id_a, id_b, id_imm;

    logic               mem_valid, mem_regwen, mem_load, mem_store;
    cpu_pkg::reg_addr_t mem_rd;
    cpu_pkg::word_t     mem_result, mem_store_data;

    operand_stage i_operand (
        .CLK, .nRST, .op_valid, .op_alu, .op_rs, .op_rt, .op_rd, .op_imm,
        .op_alusrc, .op_regwen, .op_load, .op_store, .freeze,
        .ex_load (id_load),
        .ex_rd   (id_rd),
        .rs_addr, .rt_addr, .rs_data, .rt_data, .credit_return,
        .id_valid, .id_alu, .id_rs, .id_rt, .id_rd, .id_a, .id_b, .id_imm,
        .id_alusrc, .id_regwen, .id_load, .id_store
    );

    // writeback latch drives the write port and the retire record
    register_file i_regfile (
        .CLK, .nRST, .rs_addr, .rt_addr, .rs_data, .rt_data,
        .wen     (retire_regwen),
        .wr_addr (retire_rd),
        .wr_data (retire_data)
    );

    execute_stage i_execute (
        .CLK, .nRST, .freeze,
        .id_valid, .id_alu, .id_rs, .id_rt, .id_rd, .id_a, .id_b, .id_imm,
        .id_alusrc, .id_regwen, .id_load, .id_store,
        .mem_fwd_data   (mem_result),
        .wb_fwd_data    (retire_data),
        .mem_rd         (mem_rd),
        .wb_rd          (retire_rd),
        .mem_regwen     (mem_regwen),
        .wb_regwen      (retire_regwen),
        .mem_load       (mem_load),
        .mem_valid      (mem_valid),
        .mem_rd_out     (mem_rd),
        .mem_regwen_out (mem_regwen),
        .mem_load_out   (mem_load),
        .mem_store_out  (mem_store),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data)
    );

    memory_stage i_memory (
        .CLK, .nRST, .mem_wait, .mem_valid, .mem_rd, .mem_regwen, .mem_load,
        .mem_store, .mem_result, .mem_store_data, .freeze,
        .wb_valid  (retire_valid),
        .wb_rd     (retire_rd),
        .wb_regwen (retire_regwen),
        .wb_data   (retire_data)
    );

endmodule

/* testbench/tb_datapath.sv */
// datapath testbench: credit-limited random issue, in-order reference model, retire scoreboard
module tb_datapath;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        cpu_pkg::reg_addr_t rd;
        logic               regwen;
        cpu_pkg::word_t     data;
    } retire_t;

    logic               CLK;
    logic               nRST;
    logic               op_valid;
    cpu_pkg::alu_op_t   op_alu;
    cpu_pkg::reg_addr_t op_rs;
    cpu_pkg::reg_addr_t op_rt;
    cpu_pkg::reg_addr_t op_rd;
    cpu_pkg::word_t     op_imm;
    logic               op_alusrc;
    logic               op_regwen;
    logic               op_load;
    logic               op_store;
    logic               mem_wait = 1'b0;
    logic               credit_return;
    logic               retire_valid;
    cpu_pkg::reg_addr_t retire_rd;
    logic               retire_regwen;
    cpu_pkg::word_t     retire_data;

    // architectural state seen by the reference model
    cpu_pkg::word_t ref_regs [cpu_pkg::REG_COUNT];
    cpu_pkg::word_t ref_mem  [cpu_pkg::DMEM_WORDS];
    retire_t        exp_q [$];
    retire_t        expected;

    string test_name;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    issued = 0;
    int    returns = 0;
    int    occupancy = 0;
    int    test_ops;
    int    base_returns;
    int    base_errors;
    int    burst_left = 0;
    bit    timed_out = 1'b0;
    bit    wait_enable = 1'b0;

    datapath_top i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // expected result of one operation, applied to the model state in issue order
    function automatic cpu_pkg::word_t model_op(input cpu_pkg::alu_op_t alu,
                                                input cpu_pkg::reg_addr_t rs,
                                                input cpu_pkg::reg_addr_t rt,
                                                input cpu_pkg::reg_addr_t rd,
                                                input cpu_pkg::word_t imm,
                                                input logic alusrc,
                                                input logic regwen,
                                                input logic load,
                                                input logic store);
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t res;
        cpu_pkg::word_t data;
        logic [5:0]     addr;
        a = ref_regs[rs];
        b = alusrc ? imm : ref_regs[rt];
        case (alu)
            cpu_pkg::ADD:  res = a + b;
            cpu_pkg::SUB:  res = a - b;
            cpu_pkg::AND:  res = a & b;
            cpu_pkg::OR:   res = a | b;
            cpu_pkg::XOR:  res = a ^ b;
            cpu_pkg::NOR:  res = ~(a | b);
            cpu_pkg::SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::SLTU: res = (a < b) ? 32'd1 : 32'd0;
            cpu_pkg::SLL:  res = a << b[4:0];
            cpu_pkg::SRL:  res = a >> b[4:0];
            default:       res = '0;
        endcase
        // word address from byte address bits 7:2
        addr = res[7:2];
        if (load) begin
            data = ref_mem[addr];
        end else if (store) begin
            data = ref_regs[rt];
            ref_mem[addr] = data;
        end else begin
            data = res;
        end
        if (regwen && rd != '0) begin
            ref_regs[rd] = data;
        end
        return data;
    endfunction

    function automatic int credits_left();
        return cpu_pkg::ISSUE_CREDITS - (issued - returns);
    endfunction

    task automatic issue_op(input cpu_pkg::alu_op_t alu, input cpu_pkg::reg_addr_t rs,
                            input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rd,
                            input cpu_pkg::word_t imm, input logic alusrc,
                            input logic regwen, input logic load, input logic store);
        int      waited;
        retire_t rec;
        waited = 0;
        if (timed_out) return;
        @(posedge CLK);
        while (credits_left() == 0 && waited < TIMEOUT) begin
            op_valid <= 1'b0;
            @(posedge CLK);
            waited++;
        end
        if (credits_left() == 0) begin
            op_valid <= 1'b0;
            timed_out = 1'b1;
            $display("no credit came back within %0d cycles in test %s", TIMEOUT, test_name);
        end else begin
            rec.rd     = rd;
            rec.regwen = regwen;
            rec.data   = model_op(alu, rs, rt, rd, imm, alusrc, regwen, load, store);
            exp_q.push_back(rec);
            op_valid  <= 1'b1;
            op_alu    <= alu;
            op_rs     <= rs;
            op_rt     <= rt;
            op_rd     <= rd;
            op_imm    <= imm;
            op_alusrc <= alusrc;
            op_regwen <= regwen;
            op_load   <= load;
            op_store  <= store;
            issued++;
            test_ops++;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            op_valid <= 1'b0;
        end
    endtask

    task automatic alu_rr(input cpu_pkg::alu_op_t alu, input cpu_pkg::reg_addr_t rs,
                          input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rd);
        issue_op(alu, rs, rt, rd, '0, 1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic alu_ri(input cpu_pkg::alu_op_t alu, input cpu_pkg::reg_addr_t rs,
                          input cpu_pkg::word_t imm, input cpu_pkg::reg_addr_t rd);
        issue_op(alu, rs, '0, rd, imm, 1'b1, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic load_word(input cpu_pkg::reg_addr_t base, input cpu_pkg::word_t off,
                             input cpu_pkg::reg_addr_t rd);
        issue_op(cpu_pkg::ADD, base, '0, rd, off, 1'b1, 1'b1, 1'b1, 1'b0);
    endtask

    task automatic store_word(input cpu_pkg::reg_addr_t base, input cpu_pkg::reg_addr_t src,
                              input cpu_pkg::word_t off);
        issue_op(cpu_pkg::ADD, base, src, '0, off, 1'b1, 1'b0, 1'b0, 1'b1);
    endtask

    // one random load, store or ALU op; mem_pct sets the share of memory traffic
    task automatic random_op(input int mem_pct);
        int pick;
        pick = $urandom_range(0, 99);
        if (pick < mem_pct / 2) begin
            load_word(5'($urandom_range(0, 31)), $urandom_range(0, 255),
                      5'($urandom_range(0, 31)));
        end else if (pick < mem_pct) begin
            store_word(5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)),
                       $urandom_range(0, 255));
        end else begin
            issue_op(cpu_pkg::alu_op_t'($urandom_range(0, 9)), 5'($urandom_range(0, 31)),
                     5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)), $urandom,
                     1'($urandom_range(0, 1)), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_ops     = 0;
        base_returns = returns;
        base_errors  = errors;
    endtask

    // wait for every outstanding retire, then balance credits against issues
    task automatic finish_test();
        int waited;
        waited = 0;
        wait_enable = 1'b0;
        @(posedge CLK);
        op_valid <= 1'b0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge CLK);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timed_out = 1'b1;
            $display("retire never came for %0d ops in test %s", exp_q.size(), test_name);
        end
        @(posedge CLK);
        checks++;
        assert (returns - base_returns == test_ops) else begin
            $display("CHECK FAILED test %s credit_return count: expected %0d actual %0d",
                     test_name, test_ops, returns - base_returns);
            errors++;
        end
        $display("test %s: %0d ops, %0d errors", test_name, test_ops, errors - base_errors);
        tests_run++;
    endtask

    // scoreboard and queue occupancy monitor
    always @(posedge CLK) begin
        if (nRST) begin
            occupancy = occupancy + int'(op_valid) - int'(credit_return);
            assert (occupancy >= 0 && occupancy <= cpu_pkg::ISSUE_CREDITS) else begin
                $display("queue occupancy %0d outside 0 to %0d in test %s",
                         occupancy, cpu_pkg::ISSUE_CREDITS, test_name);
                errors++;
            end
            if (credit_return) begin
                returns <= returns + 1;
            end
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    $display("retire with no operation outstanding in test %s", test_name);
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    checks += 2;
                    assert (retire_data == expected.data) else begin
                        $display("CHECK FAILED test %s retire_data: expected %h actual %h",
                                 test_name, expected.data, retire_data);
                        errors++;
                    end
                    assert ({retire_regwen, retire_rd} == {expected.regwen, expected.rd}) else begin
                        $display("CHECK FAILED test %s regwen/rd: expected %b/%0d actual %b/%0d",
                                 test_name, expected.regwen, expected.rd,
                                 retire_regwen, retire_rd);
                        errors++;
                    end
                end
            end
        end
    end

    // random wait bursts while enabled
    always @(posedge CLK) begin
        if (!wait_enable) begin
            burst_left = 0;
            mem_wait <= 1'b0;
        end else if (burst_left > 0) begin
            burst_left--;
            mem_wait <= 1'b1;
        end else if ($urandom_range(0, 3) == 0) begin
            burst_left = $urandom_range(1, 5);
            mem_wait <= 1'b1;
        end else begin
            mem_wait <= 1'b0;
        end
    end

    initial begin
        cpu_pkg::reg_addr_t prev;
        cpu_pkg::reg_addr_t dst;
        cpu_pkg::reg_addr_t base;
        cpu_pkg::word_t     off;
        void'($urandom(76));
        nRST      = 1'b0;
        op_valid  = 1'b0;
        op_alu    = cpu_pkg::ADD;
        op_rs     = '0;
        op_rt     = '0;
        op_rd     = '0;
        op_imm    = '0;
        op_alusrc = 1'b0;
        op_regwen = 1'b0;
        op_load   = 1'b0;
        op_store  = 1'b0;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        idle(2);

        start_test("alu_random");
        for (int r = 1; r < 32; r++) begin
            alu_ri(cpu_pkg::ADD, '0, $urandom, 5'(r));
        end
        for (int i = 0; i < 40; i++) begin
            random_op(0);
        end
        // r0 ignores writes
        alu_ri(cpu_pkg::ADD, '0, 32'h1234_5678, '0);
        alu_rr(cpu_pkg::OR, '0, '0, 5'd7);
        alu_rr(cpu_pkg::ADD, 5'd7, '0, 5'd8);
        finish_test();

        start_test("forwarding");
        for (int gap = 0; gap < 3; gap++) begin
            prev = 5'($urandom_range(1, 31));
            for (int i = 0; i < 10; i++) begin
                dst = 5'($urandom_range(1, 31));
                if (i % 3 == 2) begin
                    alu_ri(cpu_pkg::alu_op_t'($urandom_range(0, 9)), prev, $urandom, dst);
                end else begin
                    alu_rr(cpu_pkg::alu_op_t'($urandom_range(0, 9)), prev,
                           (i % 2 == 0) ? prev : 5'($urandom_range(0, 31)), dst);
                end
                idle(gap);
                prev = dst;
            end
        end
        finish_test();

        start_test("load_use");
        for (int i = 0; i < 12; i++) begin
            base = 5'($urandom_range(1, 31));
            off  = $urandom_range(0, 63) * 4;
            dst  = 5'($urandom_range(1, 31));
            store_word(base, 5'($urandom_range(0, 31)), off);
            load_word(base, off, dst);
            alu_rr(cpu_pkg::alu_op_t'($urandom_range(0, 9)), dst,
                   (i % 2 == 0) ? dst : 5'($urandom_range(0, 31)), 5'($urandom_range(1, 31)));
        end
        finish_test();

        start_test("mem_wait");
        wait_enable = 1'b1;
        for (int i = 0; i < 60; i++) begin
            random_op(60);
            if ($urandom_range(0, 3) == 0) begin
                idle(1);
            end
        end
        finish_test();

        start_test("credits");
        wait_enable = 1'b1;
        for (int i = 0; i < 48; i++) begin
            random_op(80);
        end
        finish_test();

        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/forwarding_unit.sv
hdl/register_file.sv
hdl/operand_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/datapath_top.sv
testbench/tb_datapath.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_datapath
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx 'No errors' $(LOG)

check:
	@grep -qx 'No errors' $(LOG) && echo PASS || { echo FAIL; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
